//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only on the pass line
verilator --binary --timing --assert -f tb.f --top-module MmioSubsystemTb -Mdir obj_dir \
	|| { echo "run.sh: build failed"; exit 1; }
out=$(./obj_dir/VMmioSubsystemTb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All checks passed" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

//--- source/BusArbiter.sv
/* Round-robin grant of one Wishbone classic bus between two masters.
   A master keeps the grant as long as it holds cyc, so it should drop cyc
   between accesses to let the other side in. Unmapped regions ack with zero. */
`timescale 1ns/10ps
`default_nettype none

module BusArbiter (
	input wire logic clock,
	input wire logic rst,
	input wire MmioPkg::WbRequest master0Req,
	input wire MmioPkg::WbRequest master1Req,
	output MmioPkg::WbResponse master0Resp,
	output MmioPkg::WbResponse master1Resp,
	output MmioPkg::WbRequest periphReq,
	output logic timerSel,
	output logic uartSel,
	output logic gpioSel,
	input wire MmioPkg::WbResponse timerResp,
	input wire MmioPkg::WbResponse uartResp,
	input wire MmioPkg::WbResponse gpioResp
);
	import MmioPkg::*;

	ArbState arbState;
	logic lastGrant;
	PeriphSelect periphSel;
	logic periphStb;
	logic noneAck;
	WbResponse selResp;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			arbState <= ArbIdle;
			lastGrant <= 1'b1;
			noneAck <= 1'b0;
		end
		else
		begin
			// unmapped region answers by itself one cycle after stb
			noneAck <= periphStb && periphSel == SelNone && !noneAck;
			case (arbState)
				ArbIdle:
				begin
					if (master0Req.cyc && (!master1Req.cyc || lastGrant))
					begin
						arbState <= ArbBusy0;
						lastGrant <= 1'b0;
					end
					else if (master1Req.cyc)
					begin
						arbState <= ArbBusy1;
						lastGrant <= 1'b1;
					end
				end
				ArbBusy0:
				begin
					if (!master0Req.cyc)
						arbState <= ArbIdle;
				end
				ArbBusy1:
				begin
					if (!master1Req.cyc)
						arbState <= ArbIdle;
				end
				default:
					arbState <= ArbIdle;
			endcase
		end
	end

	assign periphReq = (arbState == ArbBusy0) ? master0Req :
		(arbState == ArbBusy1) ? master1Req : '0;
	assign periphStb = periphReq.cyc && periphReq.stb;

	always_comb
	begin
		case (periphReq.addr[11:8])
			4'h0: periphSel = SelTimer;
			4'h1: periphSel = SelUart;
			4'h2: periphSel = SelGpio;
			default: periphSel = SelNone;
		endcase
	end

	assign timerSel = periphStb && periphSel == SelTimer;
	assign uartSel = periphStb && periphSel == SelUart;
	assign gpioSel = periphStb && periphSel == SelGpio;

	always_comb
	begin
		case (periphSel)
			SelTimer: selResp = timerResp;
			SelUart: selResp = uartResp;
			SelGpio: selResp = gpioResp;
			default: selResp = '{ack: noneAck, readData: '0};
		endcase
	end

	// the waiting master sees nothing until it is granted
	assign master0Resp = (arbState == ArbBusy0) ? selResp : '0;
	assign master1Resp = (arbState == ArbBusy1) ? selResp : '0;

	ackToRequester: assert property (@(posedge clock) disable iff (rst)
		!(master0Resp.ack && !master0Req.stb) && !(master1Resp.ack && !master1Req.stb));
	periphAckFollowsSel: assert property (@(posedge clock) disable iff (rst)
		(timerSel || uartSel || gpioSel) && !selResp.ack |=> selResp.ack);

endmodule

`default_nettype wire

//--- source/GpioPort.sv
/* 32-bit GPIO with output, direction, set and clear registers.
   Direction is only an output to the pads; no tri-state drivers here. */
`timescale 1ns/10ps
`default_nettype none

module GpioPort (
	input wire logic clock,
	input wire logic rst,
	input wire MmioPkg::WbRequest bus,
	input wire logic sel,
	output MmioPkg::WbResponse resp,
	input wire logic [MmioPkg::DataBits-1:0] gpioIn,
	output logic [MmioPkg::DataBits-1:0] gpioOut,
	output logic [MmioPkg::DataBits-1:0] gpioDir
);
	import MmioPkg::*;

	logic ack;
	logic write;
	logic [DataBits-1:0] readData;
	logic [DataBits-1:0] inMeta;
	logic [DataBits-1:0] inSync;

	assign write = sel && !ack && bus.we;

	// writes land on the same edge that raises ack
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			ack <= 1'b0;
			gpioOut <= '0;
			gpioDir <= '0;
		end
		else
		begin
			ack <= sel && !ack;
			if (write)
			begin
				case (bus.addr)
					GpioOut: gpioOut <= bus.writeData;
					GpioDir: gpioDir <= bus.writeData;
					GpioSet: gpioOut <= gpioOut | bus.writeData;
					GpioClear: gpioOut <= gpioOut & ~bus.writeData;
					default: gpioOut <= gpioOut;
				endcase
			end
		end
	end

	always_ff @(posedge clock)
	begin
		inMeta <= gpioIn;
		inSync <= inMeta;
		case (bus.addr)
			GpioIn: readData <= inSync;
			GpioOut, GpioSet, GpioClear: readData <= gpioOut;
			GpioDir: readData <= gpioDir;
			default: readData <= '0;
		endcase
	end

	assign resp = '{ack: ack, readData: readData};

endmodule

`default_nettype wire

//--- source/MicroTimer.sv
/* Free-running 64-bit microsecond counter. The step in the package assumes a
   125 MHz clock; writes are acked and have no effect. */
`timescale 1ns/10ps
`default_nettype none

module MicroTimer (
	input wire logic clock,
	input wire logic rst,
	input wire MmioPkg::WbRequest bus,
	input wire logic sel,
	output MmioPkg::WbResponse resp
);
	import MmioPkg::*;

	logic [15:0] frac;
	logic [16:0] fracSum;
	logic [63:0] count;
	logic ack;
	logic [DataBits-1:0] readData;

	// carry out of bit 16 marks one microsecond
	assign fracSum = {1'b0, frac} + {1'b0, TimerFracStep};

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			frac <= '0;
			count <= '0;
			ack <= 1'b0;
		end
		else
		begin
			frac <= fracSum[15:0];
			if (fracSum[16])
				count <= count + 64'd1;
			ack <= sel && !ack;
		end
	end

	always_ff @(posedge clock)
	begin
		case (bus.addr)
			TimerLow: readData <= count[31:0];
			TimerHigh: readData <= count[63:32];
			default: readData <= '0;
		endcase
	end

	assign resp = '{ack: ack, readData: readData};

endmodule

`default_nettype wire

//--- source/MmioPkg.sv
/* Address map, timing constants and bus types shared by the MMIO subsystem.
   Every access is a full 32-bit word; there are no byte selects or bus errors.
   UartBitCycles is kept short for simulation and is not a real baud rate. */
`default_nettype none

package MmioPkg;

	localparam int AddrBits = 12;
	localparam int DataBits = 32;

	// register offsets, region taken from addr[11:8]
	localparam logic [AddrBits-1:0] TimerLow = 12'h000;
	localparam logic [AddrBits-1:0] TimerHigh = 12'h004;
	localparam logic [AddrBits-1:0] UartRxData = 12'h100;
	localparam logic [AddrBits-1:0] UartTxData = 12'h104;
	localparam logic [AddrBits-1:0] UartStatus = 12'h108;
	localparam logic [AddrBits-1:0] GpioIn = 12'h200;
	localparam logic [AddrBits-1:0] GpioOut = 12'h204;
	localparam logic [AddrBits-1:0] GpioDir = 12'h208;
	localparam logic [AddrBits-1:0] GpioSet = 12'h210;
	localparam logic [AddrBits-1:0] GpioClear = 12'h214;

	// one microsecond per carry of the 16-bit accumulator
	localparam logic [15:0] TimerFracStep = 16'd524;

	localparam int UartBitCycles = 16;
	localparam int UartCountBits = $clog2(UartBitCycles);
	localparam int UartFifoDepth = 8;
	localparam int FifoAddrBits = $clog2(UartFifoDepth);
	localparam int FifoCountBits = FifoAddrBits + 1;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [AddrBits-1:0] addr;
		logic [DataBits-1:0] writeData;
	} WbRequest;

	typedef struct packed {
		logic ack;
		logic [DataBits-1:0] readData;
	} WbResponse;

	typedef enum logic [1:0] {
		SelTimer = 2'd0,
		SelUart = 2'd1,
		SelGpio = 2'd2,
		SelNone = 2'd3
	} PeriphSelect;

	typedef enum logic [1:0] {
		ArbIdle = 2'd0,
		ArbBusy0 = 2'd1,
		ArbBusy1 = 2'd2
	} ArbState;

	typedef enum logic [1:0] {
		UartIdle = 2'd0,
		UartStart = 2'd1,
		UartData = 2'd2,
		UartStop = 2'd3
	} UartState;

endpackage

`default_nettype wire

//--- source/MmioSubsystem.sv
/* Peripheral subsystem top: two Wishbone classic masters, one shared bus,
   timer, UART and GPIO. All accesses are 32 bits wide. */
`timescale 1ns/10ps
`default_nettype none

module MmioSubsystem (
	input wire logic clock,
	input wire logic rst,
	input wire MmioPkg::WbRequest master0Req,
	input wire MmioPkg::WbRequest master1Req,
	output MmioPkg::WbResponse master0Resp,
	output MmioPkg::WbResponse master1Resp,
	output logic uartTx,
	input wire logic uartRx,
	input wire logic [MmioPkg::DataBits-1:0] gpioIn,
	output logic [MmioPkg::DataBits-1:0] gpioOut,
	output logic [MmioPkg::DataBits-1:0] gpioDir
);
	import MmioPkg::*;

	WbRequest periphReq;
	WbResponse timerResp;
	WbResponse uartResp;
	WbResponse gpioResp;
	logic timerSel;
	logic uartSel;
	logic gpioSel;

	BusArbiter arbiter (
		.clock(clock),
		.rst(rst),
		.master0Req(master0Req),
		.master1Req(master1Req),
		.master0Resp(master0Resp),
		.master1Resp(master1Resp),
		.periphReq(periphReq),
		.timerSel(timerSel),
		.uartSel(uartSel),
		.gpioSel(gpioSel),
		.timerResp(timerResp),
		.uartResp(uartResp),
		.gpioResp(gpioResp)
	);

	MicroTimer timer (
		.clock(clock),
		.rst(rst),
		.bus(periphReq),
		.sel(timerSel),
		.resp(timerResp)
	);

	UartPort uart (
		.clock(clock),
		.rst(rst),
		.bus(periphReq),
		.sel(uartSel),
		.resp(uartResp),
		.uartTx(uartTx),
		.uartRx(uartRx)
	);

	GpioPort gpio (
		.clock(clock),
		.rst(rst),
		.bus(periphReq),
		.sel(gpioSel),
		.resp(gpioResp),
		.gpioIn(gpioIn),
		.gpioOut(gpioOut),
		.gpioDir(gpioDir)
	);

endmodule

`default_nettype wire

//--- source/UartPort.sv
/* 8N1 UART with 8-entry transmit and receive FIFOs, no parity, no flow control.
   A write to a full transmit FIFO and a byte received into a full receive FIFO
   are both dropped. Reading an empty receive FIFO returns zero. */
`timescale 1ns/10ps
`default_nettype none

module UartPort (
	input wire logic clock,
	input wire logic rst,
	input wire MmioPkg::WbRequest bus,
	input wire logic sel,
	output MmioPkg::WbResponse resp,
	output logic uartTx,
	input wire logic uartRx
);
	import MmioPkg::*;

	logic [7:0] txMem [UartFifoDepth];
	logic [7:0] rxMem [UartFifoDepth];
	logic [FifoAddrBits-1:0] txWrPtr;
	logic [FifoAddrBits-1:0] txRdPtr;
	logic [FifoAddrBits-1:0] rxWrPtr;
	logic [FifoAddrBits-1:0] rxRdPtr;
	logic [FifoCountBits-1:0] txCount;
	logic [FifoCountBits-1:0] rxCount;
	logic txFull;
	logic txEmpty;
	logic rxFull;
	logic rxReady;
	logic access;
	logic txPush;
	logic txPop;
	logic rxPush;
	logic rxPop;
	logic ack;
	logic [DataBits-1:0] readData;

	UartState txState;
	UartState rxState;
	logic [UartCountBits-1:0] txCycle;
	logic [UartCountBits-1:0] rxCycle;
	logic [2:0] txBitIdx;
	logic [2:0] rxBitIdx;
	logic [7:0] txShift;
	logic [7:0] rxShift;
	logic txBitEnd;
	logic rxBitEnd;
	logic rxMidBit;
	logic rxSync1;
	logic rxSync2;
	logic rxPrev;

	assign txFull = txCount == FifoCountBits'(UartFifoDepth);
	assign txEmpty = txCount == '0;
	assign rxFull = rxCount == FifoCountBits'(UartFifoDepth);
	assign rxReady = rxCount != '0;

	assign access = sel && !ack;
	assign txPush = access && bus.we && bus.addr == UartTxData && !txFull;
	assign rxPop = access && !bus.we && bus.addr == UartRxData && rxReady;
	assign txPop = txState == UartIdle && !txEmpty;
	assign rxPush = rxState == UartStop && rxBitEnd && rxSync2 && !rxFull;

	assign txBitEnd = txCycle == UartCountBits'(UartBitCycles - 1);
	assign rxBitEnd = rxCycle == UartCountBits'(UartBitCycles - 1);
	assign rxMidBit = rxCycle == UartCountBits'(UartBitCycles / 2 - 1);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			ack <= 1'b0;
			txWrPtr <= '0;
			txRdPtr <= '0;
			txCount <= '0;
			rxWrPtr <= '0;
			rxRdPtr <= '0;
			rxCount <= '0;
		end
		else
		begin
			ack <= access;
			if (txPush)
				txWrPtr <= txWrPtr + 1'b1;
			if (txPop)
				txRdPtr <= txRdPtr + 1'b1;
			if (rxPush)
				rxWrPtr <= rxWrPtr + 1'b1;
			if (rxPop)
				rxRdPtr <= rxRdPtr + 1'b1;
			txCount <= txCount + FifoCountBits'(txPush) - FifoCountBits'(txPop);
			rxCount <= rxCount + FifoCountBits'(rxPush) - FifoCountBits'(rxPop);
		end
	end

	always_ff @(posedge clock)
	begin
		if (txPush)
			txMem[txWrPtr] <= bus.writeData[7:0];
		if (rxPush)
			rxMem[rxWrPtr] <= rxShift;
		case (bus.addr)
			UartRxData: readData <= rxReady ? {24'd0, rxMem[rxRdPtr]} : '0;
			UartStatus: readData <= {28'd0, txFull, txEmpty, rxFull, rxReady};
			default: readData <= '0;
		endcase
	end

	assign resp = '{ack: ack, readData: readData};

	// transmitter, start bit goes out the cycle after the pop
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			txState <= UartIdle;
			txCycle <= '0;
			txBitIdx <= '0;
			txShift <= '0;
			uartTx <= 1'b1;
		end
		else
		begin
			case (txState)
				UartIdle:
				begin
					txCycle <= '0;
					uartTx <= 1'b1;
					if (txPop)
					begin
						txShift <= txMem[txRdPtr];
						uartTx <= 1'b0;
						txState <= UartStart;
					end
				end
				UartStart:
				begin
					txCycle <= txCycle + 1'b1;
					if (txBitEnd)
					begin
						txBitIdx <= '0;
						uartTx <= txShift[0];
						txState <= UartData;
					end
				end
				UartData:
				begin
					txCycle <= txCycle + 1'b1;
					if (txBitEnd && txBitIdx == 3'd7)
					begin
						uartTx <= 1'b1;
						txState <= UartStop;
					end
					else if (txBitEnd)
					begin
						txBitIdx <= txBitIdx + 1'b1;
						txShift <= {1'b0, txShift[7:1]};
						uartTx <= txShift[1];
					end
				end
				default:
				begin
					txCycle <= txCycle + 1'b1;
					if (txBitEnd)
						txState <= UartIdle;
				end
			endcase
		end
	end

	// receiver samples mid-bit, counted from the start bit's falling edge
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			rxSync1 <= 1'b1;
			rxSync2 <= 1'b1;
			rxPrev <= 1'b1;
			rxState <= UartIdle;
			rxCycle <= '0;
			rxBitIdx <= '0;
			rxShift <= '0;
		end
		else
		begin
			rxSync1 <= uartRx;
			rxSync2 <= rxSync1;
			rxPrev <= rxSync2;
			case (rxState)
				UartIdle:
				begin
					rxCycle <= '0;
					if (rxPrev && !rxSync2)
						rxState <= UartStart;
				end
				UartStart:
				begin
					rxCycle <= rxMidBit ? '0 : rxCycle + 1'b1;
					rxBitIdx <= '0;
					// a start bit that is high again at mid-bit was a glitch
					if (rxMidBit)
						rxState <= rxSync2 ? UartIdle : UartData;
				end
				UartData:
				begin
					rxCycle <= rxCycle + 1'b1;
					if (rxBitEnd)
					begin
						rxShift <= {rxSync2, rxShift[7:1]};
						rxBitIdx <= rxBitIdx + 1'b1;
						if (rxBitIdx == 3'd7)
							rxState <= UartStop;
					end
				end
				default:
				begin
					rxCycle <= rxCycle + 1'b1;
					if (rxBitEnd)
						rxState <= UartIdle;
				end
			endcase
		end
	end

	txIdleHigh: assert property (@(posedge clock) disable iff (rst)
		txState == UartIdle |-> uartTx);
	ackWithSel: assert property (@(posedge clock) disable iff (rst)
		ack |-> sel);

endmodule

`default_nettype wire

//--- tb.f
source/MmioPkg.sv
source/BusArbiter.sv
source/MicroTimer.sv
source/UartPort.sv
source/GpioPort.sv
source/MmioSubsystem.sv
tb/MmioSubsystemTb.sv

//--- tb/MmioSubsystemTb.sv
/* Testbench for the MMIO subsystem with uartTx looped back into uartRx.
   The timer check assumes the package step; TimerHigh is expected to stay zero
   because a run this short never carries into the upper half. */
`timescale 1ns/10ps
`default_nettype none

module MmioSubsystemTb;
	import MmioPkg::*;

	localparam logic Master0 = 1'b0;
	localparam logic Master1 = 1'b1;
	localparam int GpioRounds = 4;
	localparam int UartBytes = 5;
	localparam int SharedRounds = 6;
	localparam int TimerGap = 1500;
	localparam logic [AddrBits-1:0] UnmappedRead = 12'h300;
	localparam logic [AddrBits-1:0] UnmappedWrite = 12'h304;
	localparam int AccessCount = 1 + GpioRounds * 8 + 2 + 2 * UartBytes + 1
		+ 2 * SharedRounds * 3 + 2 + 3;
	localparam int WatchdogCycles = AccessCount * 200 + UartBytes * 12 * UartBitCycles
		+ TimerGap;

	logic clock;
	logic rst;
	WbRequest masterReq [2];
	WbResponse masterResp [2];
	logic uartTx;
	logic [DataBits-1:0] gpioIn;
	logic [DataBits-1:0] gpioOut;
	logic [DataBits-1:0] gpioDir;

	logic [31:0] rngState = 32'd35942;
	logic [DataBits-1:0] modelOut;
	logic [DataBits-1:0] modelDir;
	logic [DataBits-1:0] modelIn;
	logic [7:0] rxModel [$];
	logic [DataBits-1:0] expectData [2];
	logic checkRead [2];
	int lastAckCycle [2];
	int cycleCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int readErrors = 0;
	int readChecks = 0;
	string testName;

	MmioSubsystem DUT (
		.clock(clock),
		.rst(rst),
		.master0Req(masterReq[0]),
		.master1Req(masterReq[1]),
		.master0Resp(masterResp[0]),
		.master1Resp(masterResp[1]),
		.uartTx(uartTx),
		.uartRx(uartTx),
		.gpioIn(gpioIn),
		.gpioOut(gpioOut),
		.gpioDir(gpioDir)
	);

	always #4 clock = ~clock;

	always @(posedge clock)
		cycleCount <= cycleCount + 1;

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// expected readback from the model registers
	function automatic logic [DataBits-1:0] expectedRead(input logic [AddrBits-1:0] address);
		case (address)
			GpioIn: return modelIn;
			GpioOut, GpioSet, GpioClear: return modelOut;
			GpioDir: return modelDir;
			TimerHigh: return '0;
			UartRxData: return (rxModel.size() > 0) ? {24'd0, rxModel[0]} : '0;
			// transmitter drained and receive FIFO empty
			UartStatus: return 32'h4;
			default: return '0;
		endcase
	endfunction

	task automatic compareRead(input logic port);
		if (checkRead[port] && masterResp[port].ack)
		begin
			readChecks++;
			assert (masterResp[port].readData == expectData[port])
			else
			begin
				readErrors++;
				$display("[FAIL] %s, master%0d: expected %08h, actual %08h", testName, port,
					expectData[port], masterResp[port].readData);
			end
		end
	endtask

	always @(posedge clock)
	begin
		compareRead(Master0);
		compareRead(Master1);
	end

	task automatic checkValue(input string name, input logic [DataBits-1:0] expected,
		input logic [DataBits-1:0] actual);
		checkCount++;
		assert (actual == expected)
		else
		begin
			errorCount++;
			$display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	task automatic busAccess(input logic port, input logic write,
		input logic [AddrBits-1:0] address, input logic [DataBits-1:0] writeValue,
		input logic check, output logic [DataBits-1:0] readValue);
		int otherAcks;
		logic done;
		otherAcks = 0;
		done = 1'b0;
		@(posedge clock);
		expectData[port] <= expectedRead(address);
		checkRead[port] <= check;
		masterReq[port] <= '{cyc: 1'b1, stb: 1'b1, we: write, addr: address,
			writeData: writeValue};
		while (!done)
		begin
			@(posedge clock);
			if (masterResp[port].ack)
				done = 1'b1;
			else if (masterResp[!port].ack)
				otherAcks++;
		end
		readValue = masterResp[port].readData;
		lastAckCycle[port] = cycleCount;
		// cyc drops here so the arbiter can hand the bus over
		masterReq[port] <= '0;
		checkRead[port] <= 1'b0;
		checkCount++;
		assert (otherAcks <= 1)
		else
		begin
			errorCount++;
			$display("master%0d was stalled through %0d accesses of the other master in %s",
				port, otherAcks, testName);
		end
	endtask

	task automatic writeWord(input logic port, input logic [AddrBits-1:0] address,
		input logic [DataBits-1:0] value);
		logic [DataBits-1:0] unused;
		busAccess(port, 1'b1, address, value, 1'b0, unused);
	endtask

	task automatic readWord(input logic port, input logic [AddrBits-1:0] address,
		input logic check, output logic [DataBits-1:0] value);
		busAccess(port, 1'b0, address, '0, check, value);
	endtask

	initial
	begin
		repeat (WatchdogCycles) @(posedge clock);
		$display("Timeout: no finish within %0d cycles, a bus access or UART byte hung",
			WatchdogCycles);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		logic [DataBits-1:0] rd0;
		logic [DataBits-1:0] rd1;
		logic [DataBits-1:0] t0;
		int c0;
		int cycles;
		int expectedDelta;
		int delta;

		clock = 1'b0;
		rst <= 1'b1;
		masterReq[0] <= '0;
		masterReq[1] <= '0;
		gpioIn <= '0;
		checkRead[0] <= 1'b0;
		checkRead[1] <= 1'b0;
		expectData[0] <= '0;
		expectData[1] <= '0;
		modelOut = '0;
		modelDir = '0;
		modelIn = '0;
		repeat (4) @(posedge clock);
		rst <= 1'b0;

		testName = "reset";
		checkValue("reset uartTx", 32'd1, {31'd0, uartTx});
		checkValue("reset gpioOut", '0, gpioOut);
		checkValue("reset gpioDir", '0, gpioDir);
		readWord(Master0, UartStatus, 1'b1, rd0);

		testName = "gpio registers";
		for (int i = 0; i < GpioRounds; i++)
		begin
			r = nextRandom();
			writeWord(Master0, GpioOut, r);
			modelOut = r;
			r = nextRandom();
			writeWord(Master0, GpioDir, r);
			modelDir = r;
			readWord(Master0, GpioOut, 1'b1, rd0);
			readWord(Master0, GpioDir, 1'b1, rd0);
			r = nextRandom();
			writeWord(Master0, GpioSet, r);
			modelOut = modelOut | r;
			readWord(Master0, GpioSet, 1'b1, rd0);
			r = nextRandom();
			writeWord(Master0, GpioClear, r);
			modelOut = modelOut & ~r;
			readWord(Master0, GpioClear, 1'b1, rd0);
			checkValue("gpioOut port", modelOut, gpioOut);
			checkValue("gpioDir port", modelDir, gpioDir);
		end

		testName = "gpio input";
		r = nextRandom();
		@(posedge clock);
		gpioIn <= r;
		modelIn = r;
		repeat (4) @(posedge clock);
		readWord(Master0, GpioIn, 1'b1, rd0);
		readWord(Master1, GpioIn, 1'b1, rd1);

		testName = "uart loopback";
		for (int i = 0; i < UartBytes; i++)
		begin
			r = nextRandom();
			rxModel.push_back(r[7:0]);
			writeWord(Master0, UartTxData, {24'd0, r[7:0]});
		end
		for (int i = 0; i < UartBytes; i++)
		begin
			do
				readWord(Master0, UartStatus, 1'b0, rd0);
			while (!rd0[0]);
			readWord(Master0, UartRxData, 1'b1, rd0);
			void'(rxModel.pop_front());
		end
		readWord(Master0, UartStatus, 1'b1, rd0);

		testName = "shared bus";
		fork
			begin
				for (int i = 0; i < SharedRounds; i++)
				begin
					r = nextRandom();
					writeWord(Master0, GpioDir, r);
					modelDir = r;
					readWord(Master0, GpioDir, 1'b1, rd0);
					readWord(Master0, TimerHigh, 1'b1, rd0);
				end
			end
			begin
				for (int i = 0; i < SharedRounds; i++)
				begin
					readWord(Master1, GpioOut, 1'b1, rd1);
					readWord(Master1, TimerHigh, 1'b1, rd1);
					readWord(Master1, GpioIn, 1'b1, rd1);
				end
			end
		join
		checkValue("gpioDir port after sharing", modelDir, gpioDir);

		testName = "timer";
		readWord(Master1, TimerLow, 1'b0, t0);
		c0 = lastAckCycle[1];
		repeat (TimerGap) @(posedge clock);
		readWord(Master1, TimerLow, 1'b0, rd1);
		cycles = lastAckCycle[1] - c0;
		expectedDelta = (cycles * int'(TimerFracStep)) / 65536;
		delta = int'(rd1 - t0);
		checkCount++;
		assert (delta >= expectedDelta - 1 && delta <= expectedDelta + 1)
		else
		begin
			errorCount++;
			$display("[FAIL] timer delta over %0d cycles: expected %0d, actual %0d",
				cycles, expectedDelta, delta);
		end

		testName = "unmapped";
		readWord(Master0, UnmappedRead, 1'b1, rd0);
		writeWord(Master0, UnmappedWrite, nextRandom());
		checkValue("gpioOut after unmapped write", modelOut, gpioOut);
		readWord(Master0, GpioOut, 1'b1, rd0);

		repeat (2) @(posedge clock);
		$display("checks %0d, read checks %0d, errors %0d, read errors %0d",
			checkCount, readChecks, errorCount, readErrors);
		if (errorCount == 0 && readErrors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
